//--- memSubsystem.f
rtl/memPkg.sv
rtl/memRequest.sv
rtl/dataRam.sv
rtl/readData.sv
rtl/memResponse.sv
rtl/resultQueue.sv
rtl/memSubsystem.sv
dv/memSubsystem_properties.sv
dv/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build, run, then look for the fail line in the log
rm -f sim.log \
    && verilator --binary --timing --assert -f memSubsystem.f --top-module memSubsystemTb \
    && ./obj_dir/VmemSubsystemTb > sim.log 2>&1 \
    || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

//--- dv/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int fillRows = 8;
    localparam int fixedRows = 3;
    localparam int numRows = fillRows + fixedRows + 40;
    localparam int clkPeriod = 40;
    localparam int timeoutCycles = numRows * 20;

    logic clk;
    logic resetn;
    logic inValid;
    logic creditIn;
    logic creditOut;
    logic outValid;
    memPkg::memOp                op         [memPkg::numLanes];
    memPkg::memSize              size       [memPkg::numLanes];
    logic                        signedLoad [memPkg::numLanes];
    logic [31:0]                 addr       [memPkg::numLanes];
    logic [31:0]                 storeData  [memPkg::numLanes];
    logic [memPkg::destBits-1:0] dest       [memPkg::numLanes];
    logic                        outWrite   [memPkg::numLanes];
    logic [memPkg::destBits-1:0] outDest    [memPkg::numLanes];
    logic [31:0]                 outData    [memPkg::numLanes];

    // stimulus columns, then expected columns
    memPkg::memOp                tOp     [numRows][memPkg::numLanes];
    memPkg::memSize              tSize   [numRows][memPkg::numLanes];
    logic                        tSigned [numRows][memPkg::numLanes];
    logic [31:0]                 tAddr   [numRows][memPkg::numLanes];
    logic [31:0]                 tData   [numRows][memPkg::numLanes];
    logic [memPkg::destBits-1:0] tDest   [numRows][memPkg::numLanes];
    logic                        eWrite  [numRows][memPkg::numLanes];
    logic [31:0]                 eData   [numRows][memPkg::numLanes];

    // reference memory
    logic [31:0] refMem [memPkg::ramWords];
    logic [31:0] lfsr;

    // upstream and writeback bookkeeping
    int sent = 0;
    int returned = 0;
    int resultIdx = 0;
    int delivered = 0;
    int creditSeen = 0;
    int wbSent = 0;

    memSubsystem uut (
        .clk        (clk),
        .resetn     (resetn),
        .inValid    (inValid),
        .op         (op),
        .size       (size),
        .signedLoad (signedLoad),
        .addr       (addr),
        .storeData  (storeData),
        .dest       (dest),
        .creditOut  (creditOut),
        .outValid   (outValid),
        .outWrite   (outWrite),
        .outDest    (outDest),
        .outData    (outData),
        .creditIn   (creditIn)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic checkWrite(input int lane, input logic got, input logic exp);
        if (got !== exp) begin
            stopRun($sformatf("error @ %0t ns: bundle %0d lane %0d outWrite %b, expected %b",
                $time, resultIdx, lane, got, exp));
        end
    endtask

    task automatic checkData(input int lane, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("error @ %0t ns: bundle %0d lane %0d outData %h, expected %h",
                $time, resultIdx, lane, got, exp));
        end
    endtask

    task automatic checkDest(input int lane, input logic [memPkg::destBits-1:0] got,
                             input logic [memPkg::destBits-1:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("error @ %0t ns: bundle %0d lane %0d outDest %0d, expected %0d",
                $time, resultIdx, lane, got, exp));
        end
    endtask

    task automatic setLane(input int r, input int l, input memPkg::memOp o,
                           input memPkg::memSize s, input logic sgn, input int idx,
                           input int off, input logic [31:0] data, input logic [31:0] dst);
        tOp[r][l] = o;
        tSize[r][l] = s;
        tSigned[r][l] = sgn;
        tAddr[r][l] = 32'(idx * 4 + off);
        tData[r][l] = data;
        tDest[r][l] = dst[memPkg::destBits-1:0];
    endtask

    task automatic buildTable();
        logic [31:0] pick;
        logic [31:0] data;
        logic [31:0] dst;
        memPkg::memOp o;
        memPkg::memSize s;
        logic sgn;
        int idx;
        int off;
        // word stores so that words 0 to 15 hold known data
        for (int r = 0; r < fillRows; r++) begin
            for (int l = 0; l < memPkg::numLanes; l++) begin
                data = takeBits(32);
                dst = takeBits(5);
                setLane(r, l, memPkg::opStore, memPkg::sizeWord, 1'b0, 2 * r + l, 0, data, dst);
            end
        end
        // same-word pairs: overlapping stores, then load beside store
        setLane(fillRows, 0, memPkg::opStore, memPkg::sizeWord, 1'b0, 3, 0, 32'h1234f6a5, 1);
        setLane(fillRows, 1, memPkg::opStore, memPkg::sizeHalf, 1'b0, 3, 2, 32'h0000c381, 2);
        setLane(fillRows + 1, 0, memPkg::opLoad, memPkg::sizeWord, 1'b0, 3, 0, 0, 3);
        setLane(fillRows + 1, 1, memPkg::opStore, memPkg::sizeByte, 1'b0, 3, 0, 32'h000000e7, 4);
        setLane(fillRows + 2, 0, memPkg::opLoad, memPkg::sizeByte, 1'b1, 3, 0, 0, 5);
        setLane(fillRows + 2, 1, memPkg::opLoad, memPkg::sizeHalf, 1'b0, 3, 2, 0, 6);
        for (int r = fillRows + fixedRows; r < numRows; r++) begin
            for (int l = 0; l < memPkg::numLanes; l++) begin
                pick = takeBits(2);
                o = (pick == 0) ? memPkg::opNone : (pick == 3) ? memPkg::opStore : memPkg::opLoad;
                pick = takeBits(2);
                s = (pick == 0) ? memPkg::sizeByte :
                    (pick == 1) ? memPkg::sizeHalf : memPkg::sizeWord;
                sgn = (takeBits(1) != 0);
                idx = takeBits(4);
                // offset aligned to the access width
                if (s == memPkg::sizeByte) off = takeBits(2);
                else if (s == memPkg::sizeHalf) off = 2 * takeBits(1);
                else off = 0;
                data = takeBits(32);
                dst = takeBits(5);
                setLane(r, l, o, s, sgn, idx, off, data, dst);
            end
        end
    endtask

    task automatic predict();
        logic [31:0] v;
        int idx;
        int off;
        int nBytes;
        for (int r = 0; r < numRows; r++) begin
            // loads first, a bundle sees memory from before its own stores
            for (int l = 0; l < memPkg::numLanes; l++) begin
                idx = int'(tAddr[r][l] >> 2);
                off = int'(tAddr[r][l] & 32'd3);
                v = refMem[idx] >> (8 * off);
                if (tSize[r][l] == memPkg::sizeByte) begin
                    v = v & 32'h000000ff;
                    if (tSigned[r][l] && v[7]) v = v | 32'hffffff00;
                end else if (tSize[r][l] == memPkg::sizeHalf) begin
                    v = v & 32'h0000ffff;
                    if (tSigned[r][l] && v[15]) v = v | 32'hffff0000;
                end
                eWrite[r][l] = (tOp[r][l] == memPkg::opLoad);
                eData[r][l] = v;
            end
            // stores in lane order, lane 1 lands last
            for (int l = 0; l < memPkg::numLanes; l++) begin
                idx = int'(tAddr[r][l] >> 2);
                off = int'(tAddr[r][l] & 32'd3);
                nBytes = (tSize[r][l] == memPkg::sizeByte) ? 1 :
                         (tSize[r][l] == memPkg::sizeHalf) ? 2 : 4;
                if (tOp[r][l] == memPkg::opStore) begin
                    for (int b = 0; b < nBytes; b++) begin
                        refMem[idx][8 * (off + b) +: 8] = tData[r][l][8 * b +: 8];
                    end
                end
            end
        end
    endtask

    task automatic applyRow(input int r);
        for (int l = 0; l < memPkg::numLanes; l++) begin
            op[l] = tOp[r][l];
            size[l] = tSize[r][l];
            signedLoad[l] = tSigned[r][l];
            addr[l] = tAddr[r][l];
            storeData[l] = tData[r][l];
            dest[l] = tDest[r][l];
        end
    endtask

    // execute side
    initial begin
        int row;
        resetn = 1'b0;
        inValid = 1'b0;
        for (int l = 0; l < memPkg::numLanes; l++) begin
            op[l] = memPkg::opNone;
            size[l] = memPkg::sizeWord;
            signedLoad[l] = 1'b0;
            addr[l] = '0;
            storeData[l] = '0;
            dest[l] = '0;
        end
        lfsr = 32'hd4ca;
        buildTable();
        predict();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        row = 0;
        while (row < numRows) begin
            @(negedge clk);
            // send only while an upstream credit is held
            if (sent - returned < memPkg::queueDepth) begin
                applyRow(row);
                inValid = 1'b1;
                sent++;
                row++;
            end else begin
                inValid = 1'b0;
            end
        end
        @(negedge clk);
        inValid = 1'b0;
        wait (resultIdx == numRows);
        // quiet period to catch a duplicated result
        repeat (10) @(posedge clk);
        if (returned != numRows) begin
            stopRun($sformatf("creditOut pulsed %0d times for %0d bundles", returned, numRows));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // writeback side, credits return after random delays
    initial begin
        creditIn = 1'b0;
        @(posedge resetn);
        forever begin
            @(negedge clk);
            if (delivered > wbSent && takeBits(2) == 0) begin
                creditIn = 1'b1;
                wbSent++;
            end else begin
                creditIn = 1'b0;
            end
        end
    end

    // outputs sampled on the rising edge
    always @(posedge clk) begin
        if (resetn) begin
            if (sent == 0 && (outValid || creditOut)) begin
                stopRun("outValid or creditOut went high before any bundle was accepted");
            end
            // every result sent frees one queue slot upstream
            if (creditOut !== outValid) begin
                stopRun("creditOut and outValid did not pulse in the same cycle");
            end
            if (creditOut) returned++;
            if (creditIn) creditSeen++;
            if (outValid) begin
                if (resultIdx >= numRows) begin
                    stopRun("result queue sent more results than bundles issued");
                end
                for (int l = 0; l < memPkg::numLanes; l++) begin
                    checkWrite(l, outWrite[l], eWrite[resultIdx][l]);
                    checkDest(l, outDest[l], tDest[resultIdx][l]);
                    if (eWrite[resultIdx][l]) checkData(l, outData[l], eData[resultIdx][l]);
                end
                resultIdx++;
                delivered++;
                if (delivered > memPkg::wbCredits + creditSeen) begin
                    stopRun("result queue sent more results than writeback credits allowed");
                end
            end
        end
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        stopRun("timeout: not every bundle came back from the result queue");
    end

endmodule

//--- dv/memSubsystem_properties.sv
`timescale 1ns/1ps

module queueProperties (
    input logic                          clk,
    input logic                          resetn,
    input logic                          push,
    input logic [memPkg::countBits-1:0]  count,
    input logic [memPkg::creditBits-1:0] credits,
    input logic                          creditIn,
    input logic                          outValid
);

    // writeback credits counted from the port pulses alone
    int held;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held <= memPkg::wbCredits;
        end else begin
            held <= held + int'(creditIn) - int'(outValid);
        end
    end

    // a full queue holds every upstream credit, so nothing is in flight
    noPushWhenFull: assert property (@(posedge clk) disable iff (!resetn)
        !(push && count == memPkg::countBits'(memPkg::queueDepth)))
        else $error("result queue pushed while full");

    // writeback credit needed, held or arriving now
    sendNeedsCredit: assert property (@(posedge clk) disable iff (!resetn)
        outValid |-> (held > 0 || creditIn))
        else $error("result sent without a writeback credit");

    // internal counter in step with the port pulses
    creditsTrack: assert property (@(posedge clk) disable iff (!resetn)
        int'(credits) == held)
        else $error("writeback credit counter out of step with creditIn and outValid");

endmodule

bind resultQueue queueProperties props (
    .clk       (clk),
    .resetn    (resetn),
    .push      (push),
    .count     (count),
    .credits   (credits),
    .creditIn  (creditIn),
    .outValid  (outValid)
);

//--- rtl/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic                        clk,
    input  logic                        resetn,
    // execute side
    input  logic                        inValid,
    input  memPkg::memOp                op         [memPkg::numLanes],
    input  memPkg::memSize              size       [memPkg::numLanes],
    input  logic                        signedLoad [memPkg::numLanes],
    input  logic [31:0]                 addr       [memPkg::numLanes],
    input  logic [31:0]                 storeData  [memPkg::numLanes],
    input  logic [memPkg::destBits-1:0] dest       [memPkg::numLanes],
    output logic                        creditOut,
    // writeback side
    output logic                        outValid,
    output logic                        outWrite   [memPkg::numLanes],
    output logic [memPkg::destBits-1:0] outDest    [memPkg::numLanes],
    output logic [31:0]                 outData    [memPkg::numLanes],
    input  logic                        creditIn
);

    // request to RAM
    logic                         ramWe     [memPkg::numLanes];
    logic [memPkg::indexBits-1:0] ramIndex  [memPkg::numLanes];
    logic [31:0]                  ramWdata  [memPkg::numLanes];
    logic [3:0]                   ramStrobe [memPkg::numLanes];
    logic [31:0]                  ramRdata  [memPkg::numLanes];

    // response into the queue
    logic                        respValid;
    logic                        respWrite [memPkg::numLanes];
    logic [memPkg::destBits-1:0] respDest  [memPkg::numLanes];
    logic [31:0]                 respData  [memPkg::numLanes];

    memRequest request (
        .op        (op),
        .size      (size),
        .addr      (addr),
        .storeData (storeData),
        .inValid   (inValid),
        .ramWe     (ramWe),
        .ramIndex  (ramIndex),
        .ramWdata  (ramWdata),
        .ramStrobe (ramStrobe)
    );

    dataRam ram (
        .clk       (clk),
        .ramWe     (ramWe),
        .ramIndex  (ramIndex),
        .ramWdata  (ramWdata),
        .ramStrobe (ramStrobe),
        .ramRdata  (ramRdata)
    );

    // control delayed one cycle to meet the read data
    memResponse response (
        .clk        (clk),
        .resetn     (resetn),
        .inValid    (inValid),
        .op         (op),
        .size       (size),
        .signedLoad (signedLoad),
        .addr       (addr),
        .dest       (dest),
        .ramRdata   (ramRdata),
        .respValid  (respValid),
        .respWrite  (respWrite),
        .respDest   (respDest),
        .respData   (respData)
    );

    resultQueue queue (
        .clk       (clk),
        .resetn    (resetn),
        .respValid (respValid),
        .respWrite (respWrite),
        .respDest  (respDest),
        .respData  (respData),
        .creditIn  (creditIn),
        .outValid  (outValid),
        .outWrite  (outWrite),
        .outDest   (outDest),
        .outData   (outData),
        .creditOut (creditOut)
    );

endmodule

//--- rtl/resultQueue.sv
`timescale 1ns/1ps

module resultQueue (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        respValid,
    input  logic                        respWrite [memPkg::numLanes],
    input  logic [memPkg::destBits-1:0] respDest  [memPkg::numLanes],
    input  logic [31:0]                 respData  [memPkg::numLanes],
    input  logic                        creditIn,
    output logic                        outValid,
    output logic                        outWrite  [memPkg::numLanes],
    output logic [memPkg::destBits-1:0] outDest   [memPkg::numLanes],
    output logic [31:0]                 outData   [memPkg::numLanes],
    output logic                        creditOut
);

    // one entry holds both lanes of a bundle
    logic                        qWrite [memPkg::queueDepth][memPkg::numLanes];
    logic [memPkg::destBits-1:0] qDest  [memPkg::queueDepth][memPkg::numLanes];
    logic [31:0]                 qData  [memPkg::queueDepth][memPkg::numLanes];

    logic [memPkg::ptrBits-1:0]    wrPtr;
    logic [memPkg::ptrBits-1:0]    rdPtr;
    logic [memPkg::countBits-1:0]  count;
    logic [memPkg::creditBits-1:0] credits;
    logic                          push;
    logic                          pop;
    logic                          empty;

    // upstream credits keep the queue from overflowing
    assign push  = respValid;
    assign empty = (count == '0);

    // a credit arriving this cycle can be spent right away
    assign pop = !empty && ((credits != '0) || creditIn);

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < memPkg::numLanes; i++) begin
                qWrite[wrPtr][i] <= respWrite[i];
                qDest[wrPtr][i]  <= respDest[i];
                qData[wrPtr][i]  <= respData[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= memPkg::creditBits'(memPkg::wbCredits);
        end else begin
            // depth is a power of two, pointers wrap on their own
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop) rdPtr <= rdPtr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case ({creditIn, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // head entry goes straight out on pop
    always_comb begin
        for (int i = 0; i < memPkg::numLanes; i++) begin
            outWrite[i] = qWrite[rdPtr][i];
            outDest[i]  = qDest[rdPtr][i];
            outData[i]  = qData[rdPtr][i];
        end
    end

    assign outValid  = pop;
    // freed slot goes back to execute
    assign creditOut = pop;

endmodule

//--- rtl/memResponse.sv
`timescale 1ns/1ps

module memResponse (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        inValid,
    input  memPkg::memOp                op         [memPkg::numLanes],
    input  memPkg::memSize              size       [memPkg::numLanes],
    input  logic                        signedLoad [memPkg::numLanes],
    input  logic [31:0]                 addr       [memPkg::numLanes],
    input  logic [memPkg::destBits-1:0] dest       [memPkg::numLanes],
    input  logic [31:0]                 ramRdata   [memPkg::numLanes],
    output logic                        respValid,
    output logic                        respWrite  [memPkg::numLanes],
    output logic [memPkg::destBits-1:0] respDest   [memPkg::numLanes],
    output logic [31:0]                 respData   [memPkg::numLanes]
);

    // bundle valid, lines up with the RAM read register
    logic validQ;

    // lane control captured at accept
    memPkg::memOp                opQ     [memPkg::numLanes];
    memPkg::memSize              sizeQ   [memPkg::numLanes];
    logic                        signedQ [memPkg::numLanes];
    logic [1:0]                  offsetQ [memPkg::numLanes];
    logic [memPkg::destBits-1:0] destQ   [memPkg::numLanes];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < memPkg::numLanes; i++) begin
            opQ[i]     <= op[i];
            sizeQ[i]   <= size[i];
            signedQ[i] <= signedLoad[i];
            offsetQ[i] <= addr[i][1:0];
            destQ[i]   <= dest[i];
        end
    end

    assign respValid = validQ;

    for (genvar i = 0; i < memPkg::numLanes; i++) begin : laneGen
        // extract this lane's load value from its RAM port
        readData extract (
            .word       (ramRdata[i]),
            .offset     (offsetQ[i]),
            .size       (sizeQ[i]),
            .signedLoad (signedQ[i]),
            .value      (respData[i])
        );

        // only loads write the register file
        assign respWrite[i] = validQ && (opQ[i] == memPkg::opLoad);
        assign respDest[i]  = destQ[i];
    end

endmodule

//--- rtl/readData.sv
`timescale 1ns/1ps

module readData (
    input  logic [31:0]    word,
    input  logic [1:0]     offset,
    input  memPkg::memSize size,
    input  logic           signedLoad,
    output logic [31:0]    value
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // byte picked straight from the offset
    assign byteSel = word[{offset, 3'b000} +: 8];

    // half only needs the upper offset bit, accesses are aligned
    assign halfSel = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (size)
            memPkg::sizeByte: begin
                value = signedLoad ? {{24{byteSel[7]}}, byteSel} : {24'b0, byteSel};
            end
            memPkg::sizeHalf: begin
                value = signedLoad ? {{16{halfSel[15]}}, halfSel} : {16'b0, halfSel};
            end
            default: begin
                // whole word, no extension needed
                value = word;
            end
        endcase
    end

endmodule

//--- rtl/dataRam.sv
`timescale 1ns/1ps

module dataRam (
    input  logic                         clk,
    input  logic                         ramWe     [memPkg::numLanes],
    input  logic [memPkg::indexBits-1:0] ramIndex  [memPkg::numLanes],
    input  logic [31:0]                  ramWdata  [memPkg::numLanes],
    input  logic [3:0]                   ramStrobe [memPkg::numLanes],
    output logic [31:0]                  ramRdata  [memPkg::numLanes]
);

    // one word array shared by both ports
    logic [31:0] mem [memPkg::ramWords];

    always_ff @(posedge clk) begin
        // ports handled in lane order
        // a later nonblocking write to the same byte wins, so lane 1 overrides
        for (int p = 0; p < memPkg::numLanes; p++) begin
            // read sees the word as it was before this edge
            ramRdata[p] <= mem[ramIndex[p]];

            if (ramWe[p]) begin
                for (int b = 0; b < 4; b++) begin
                    if (ramStrobe[p][b]) begin
                        mem[ramIndex[p]][8*b +: 8] <= ramWdata[p][8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- rtl/memRequest.sv
`timescale 1ns/1ps

module memRequest (
    input  memPkg::memOp              op        [memPkg::numLanes],
    input  memPkg::memSize            size      [memPkg::numLanes],
    input  logic [31:0]               addr      [memPkg::numLanes],
    input  logic [31:0]               storeData [memPkg::numLanes],
    input  logic                      inValid,
    output logic                      ramWe     [memPkg::numLanes],
    output logic [memPkg::indexBits-1:0] ramIndex [memPkg::numLanes],
    output logic [31:0]               ramWdata  [memPkg::numLanes],
    output logic [3:0]                ramStrobe [memPkg::numLanes]
);

    always_comb begin
        for (int i = 0; i < memPkg::numLanes; i++) begin
            // word index, loads and stores both use it
            ramIndex[i] = addr[i][memPkg::indexBits+1:2];

            // only a store in an accepted bundle writes
            ramWe[i] = inValid && (op[i] == memPkg::opStore);

            // move store bytes up to their byte lane
            // bits above the access width get masked by the strobe
            ramWdata[i] = storeData[i] << {addr[i][1:0], 3'b000};

            // strobe pattern by size, then shift to offset
            case (size[i])
                memPkg::sizeByte: begin
                    ramStrobe[i] = 4'b0001 << addr[i][1:0];
                end
                memPkg::sizeHalf: begin
                    // halves sit at offset 0 or 2
                    ramStrobe[i] = 4'b0011 << addr[i][1:0];
                end
                memPkg::sizeWord: begin
                    ramStrobe[i] = 4'b1111;
                end
                default: begin
                    ramStrobe[i] = 4'b0000;
                end
            endcase
        end
    end

endmodule

//--- rtl/memPkg.sv
package memPkg;

    // two instructions per bundle, lane 0 is the older one
    localparam int numLanes = 2;

    // data RAM geometry, 32-bit words
    localparam int ramWords = 256;
    localparam int indexBits = $clog2(ramWords);

    // register file destination width
    localparam int destBits = 5;

    // result queue entries
    // execute starts with this many credits
    localparam int queueDepth = 4;
    localparam int ptrBits = $clog2(queueDepth);
    localparam int countBits = $clog2(queueDepth + 1);

    // credits granted by writeback at reset
    localparam int wbCredits = 2;

    // credit counter is sized for the reset value
    // writeback never hands back more than it was given
    localparam int creditBits = $clog2(wbCredits + 1);

    // per-lane memory operation
    typedef enum logic [1:0] {
        opNone,
        opLoad,
        opStore
    } memOp;

    // access width
    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } memSize;

endpackage
